/* Bender.yml */
package:
  name: complex_alu

sources:
  # design
  - files:
      - hdl/calu_pkg.sv
      - hdl/dsp_slice.sv
      - hdl/complex_op_decoder.sv
      - hdl/complex_alu.sv
      - hdl/complex_alu_top.sv

  # simulation only
  - target: test
    files:
      - tests/complex_alu_props.sv
      - tests/complex_alu_tb.sv

/* hdl/calu_pkg.sv */
package calu_pkg;

	////////////////////////////////////////////////////////////
	// widths
	////////////////////////////////////////////////////////////

	localparam int DATA_WIDTH = 16; // one component, Q1.15
	localparam int FRAC_BITS  = 15; // product scale of Q1.15 x Q1.15
	localparam int NUM_SLICES = 4;

	// multiply-add slice ports
	localparam int PORTA_WIDTH = 30;
	localparam int PORTB_WIDTH = 18;
	localparam int PORTC_WIDTH = 48;
	localparam int PORTP_WIDTH = 48;

	// input register + three slice stages
	localparam int CALU_LATENCY = 4;

	////////////////////////////////////////////////////////////
	// vector types
	////////////////////////////////////////////////////////////

	typedef logic [2*DATA_WIDTH-1:0] cplx_t; // {re, im}
	typedef logic [DATA_WIDTH-1:0]   comp_t;

	typedef logic [PORTA_WIDTH-1:0] porta_t;
	typedef logic [PORTB_WIDTH-1:0] portb_t;
	typedef logic [PORTC_WIDTH-1:0] portc_t;
	typedef logic [PORTP_WIDTH-1:0] portp_t;

	////////////////////////////////////////////////////////////
	// operation codes and slice modes
	////////////////////////////////////////////////////////////

	// x = din_1, y = din_2, z = din_3
	typedef enum logic [1:0] {
		OP_CMUL      = 2'd0, // x * y
		OP_CMUL_CONJ = 2'd1, // x * conj(y)
		OP_CMUL_ADD  = 2'd2, // x * y + z
		OP_LOAD_Z    = 2'd3  // z, multipliers idle
	} calu_op_t;

	// post-adder function of one slice
	typedef enum logic {
		ALU_Z_PLUS_M  = 1'b0,
		ALU_Z_MINUS_M = 1'b1
	} slice_alu_t;

endpackage

/* hdl/complex_alu.sv */
`timescale 1ns/1ps

module complex_alu (
	input  logic                                         clk,
	input  logic                                         rst_n_i,
	input  calu_pkg::cplx_t                              din_1_i, // x = a + jb
	input  calu_pkg::cplx_t                              din_2_i, // y = c + jd
	input  calu_pkg::cplx_t                              din_3_i, // z = e + jf
	input  calu_pkg::slice_alu_t [calu_pkg::NUM_SLICES-1:0] slice_alu_i,
	input  logic [calu_pkg::NUM_SLICES-1:0]              use_z_i,
	input  logic [calu_pkg::NUM_SLICES-1:0]              use_mult_i,
	output calu_pkg::cplx_t                              dout_o
);

	// input registers, same edge as the decoder modes
	calu_pkg::cplx_t x_q, y_q, z_q;

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			x_q <= '0;
			y_q <= '0;
			z_q <= '0;
		end else begin
			x_q <= din_1_i;
			y_q <= din_2_i;
			z_q <= din_3_i;
		end
	end

	////////////////////////////////////////////////////////////
	// operand split and sign extension
	////////////////////////////////////////////////////////////

	calu_pkg::comp_t  a, b, c, d, e, f;
	calu_pkg::porta_t c_ext, d_ext; // y parts drive port A
	calu_pkg::portb_t a_ext, b_ext; // x parts drive port B
	calu_pkg::portc_t e_scaled, f_scaled;

	assign {a, b} = x_q;
	assign {c, d} = y_q;
	assign {e, f} = z_q;

	assign c_ext = calu_pkg::porta_t'($signed(c));
	assign d_ext = calu_pkg::porta_t'($signed(d));
	assign a_ext = calu_pkg::portb_t'($signed(a));
	assign b_ext = calu_pkg::portb_t'($signed(b));

	// addend aligned with the Q2.30 products
	assign e_scaled = calu_pkg::portc_t'($signed(e)) << calu_pkg::FRAC_BITS;
	assign f_scaled = calu_pkg::portc_t'($signed(f)) << calu_pkg::FRAC_BITS;

	////////////////////////////////////////////////////////////
	// slices, slice 1 on the top bit of the mode vectors
	////////////////////////////////////////////////////////////

	calu_pkg::portp_t p_1, p_2, p_3, p_4;

	dsp_slice u_slice_1 ( // a * c (+ e)
		.clk(clk), .rst_n_i(rst_n_i),
		.a_i(c_ext), .b_i(a_ext), .c_i(e_scaled),
		.alu_i(slice_alu_i[3]), .use_z_i(use_z_i[3]), .use_mult_i(use_mult_i[3]),
		.p_o(p_1)
	);

	dsp_slice u_slice_2 ( // b * d
		.clk(clk), .rst_n_i(rst_n_i),
		.a_i(d_ext), .b_i(b_ext), .c_i('0),
		.alu_i(slice_alu_i[2]), .use_z_i(use_z_i[2]), .use_mult_i(use_mult_i[2]),
		.p_o(p_2)
	);

	dsp_slice u_slice_3 ( // b * c (+ f)
		.clk(clk), .rst_n_i(rst_n_i),
		.a_i(c_ext), .b_i(b_ext), .c_i(f_scaled),
		.alu_i(slice_alu_i[1]), .use_z_i(use_z_i[1]), .use_mult_i(use_mult_i[1]),
		.p_o(p_3)
	);

	dsp_slice u_slice_4 ( // a * d
		.clk(clk), .rst_n_i(rst_n_i),
		.a_i(d_ext), .b_i(a_ext), .c_i('0),
		.alu_i(slice_alu_i[0]), .use_z_i(use_z_i[0]), .use_mult_i(use_mult_i[0]),
		.p_o(p_4)
	);

	// signs already applied in the slices, so always add
	calu_pkg::portp_t sum_re, sum_im;
	calu_pkg::portp_t shr_re, shr_im;

	assign sum_re = p_1 + p_2;
	assign sum_im = p_3 + p_4;
	assign shr_re = $signed(sum_re) >>> calu_pkg::FRAC_BITS;
	assign shr_im = $signed(sum_im) >>> calu_pkg::FRAC_BITS;

	assign dout_o = {shr_re[calu_pkg::DATA_WIDTH-1:0], shr_im[calu_pkg::DATA_WIDTH-1:0]};

endmodule

/* hdl/complex_alu_top.sv */
`timescale 1ns/1ps

module complex_alu_top (
	input  logic               clk,
	input  logic               rst_n_i,
	input  calu_pkg::calu_op_t op_i,
	input  logic               valid_i,
	input  calu_pkg::cplx_t    din_1_i, // x
	input  calu_pkg::cplx_t    din_2_i, // y
	input  calu_pkg::cplx_t    din_3_i, // z, addend
	output calu_pkg::cplx_t    dout_o,
	output logic               valid_o
);

	// per-slice modes, decoder to core
	calu_pkg::slice_alu_t [calu_pkg::NUM_SLICES-1:0] slice_alu;
	logic [calu_pkg::NUM_SLICES-1:0]                 use_z;
	logic [calu_pkg::NUM_SLICES-1:0]                 use_mult;

	complex_op_decoder u_decoder (
		.clk         (clk),
		.rst_n_i     (rst_n_i),
		.op_i        (op_i),
		.valid_i     (valid_i),
		.slice_alu_o (slice_alu),
		.use_z_o     (use_z),
		.use_mult_o  (use_mult),
		.valid_o     (valid_o)
	);

	complex_alu u_core (
		.clk         (clk),
		.rst_n_i     (rst_n_i),
		.din_1_i     (din_1_i),
		.din_2_i     (din_2_i),
		.din_3_i     (din_3_i),
		.slice_alu_i (slice_alu),
		.use_z_i     (use_z),
		.use_mult_i  (use_mult),
		.dout_o      (dout_o)
	);

endmodule

/* hdl/complex_op_decoder.sv */
`timescale 1ns/1ps

module complex_op_decoder (
	input  logic                                            clk,
	input  logic                                            rst_n_i,
	input  calu_pkg::calu_op_t                              op_i,
	input  logic                                            valid_i,
	output calu_pkg::slice_alu_t [calu_pkg::NUM_SLICES-1:0] slice_alu_o,
	output logic [calu_pkg::NUM_SLICES-1:0]                 use_z_o,
	output logic [calu_pkg::NUM_SLICES-1:0]                 use_mult_o,
	output logic                                            valid_o
);

	////////////////////////////////////////////////////////////
	// mode table, bit 3 is slice 1 and bit 0 is slice 4
	////////////////////////////////////////////////////////////

	calu_pkg::slice_alu_t [calu_pkg::NUM_SLICES-1:0] alu_d;
	logic [calu_pkg::NUM_SLICES-1:0]                 use_z_d;
	logic [calu_pkg::NUM_SLICES-1:0]                 use_mult_d;

	always_comb begin
		for (int i = 0; i < calu_pkg::NUM_SLICES; i++) begin
			alu_d[i] = calu_pkg::ALU_Z_PLUS_M;
		end
		use_z_d    = '0;
		use_mult_d = '0;
		case (op_i)
			calu_pkg::OP_CMUL: begin
				use_mult_d = 4'b1111;
				alu_d[2]   = calu_pkg::ALU_Z_MINUS_M; // -bd
			end
			calu_pkg::OP_CMUL_CONJ: begin
				use_mult_d = 4'b1111;
				alu_d[0]   = calu_pkg::ALU_Z_MINUS_M; // -ad
			end
			calu_pkg::OP_CMUL_ADD: begin
				use_mult_d = 4'b1111;
				use_z_d    = 4'b1010; // e on slice 1, f on slice 3
				alu_d[2]   = calu_pkg::ALU_Z_MINUS_M;
			end
			calu_pkg::OP_LOAD_Z: begin
				use_z_d = 4'b1010; // multipliers stay off
			end
			default: begin
				use_mult_d = '0;
			end
		endcase
	end

	// modes follow op_i even when idle
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			for (int i = 0; i < calu_pkg::NUM_SLICES; i++) begin
				slice_alu_o[i] <= calu_pkg::ALU_Z_PLUS_M;
			end
			use_z_o    <= '0;
			use_mult_o <= '0;
		end else begin
			slice_alu_o <= alu_d;
			use_z_o     <= use_z_d;
			use_mult_o  <= use_mult_d;
		end
	end

	////////////////////////////////////////////////////////////
	// valid delay line
	////////////////////////////////////////////////////////////

	logic [calu_pkg::CALU_LATENCY-1:0] valid_sr;

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			valid_sr <= '0;
		end else begin
			valid_sr <= {valid_sr[calu_pkg::CALU_LATENCY-2:0], valid_i};
		end
	end

	assign valid_o = valid_sr[calu_pkg::CALU_LATENCY-1]; // lines up with P

endmodule

/* hdl/dsp_slice.sv */
`timescale 1ns/1ps

module dsp_slice (
	input  logic                 clk,
	input  logic                 rst_n_i,
	input  calu_pkg::porta_t     a_i,
	input  calu_pkg::portb_t     b_i,
	input  calu_pkg::portc_t     c_i,
	input  calu_pkg::slice_alu_t alu_i,
	input  logic                 use_z_i,
	input  logic                 use_mult_i,
	output calu_pkg::portp_t     p_o
);

	////////////////////////////////////////////////////////////
	// stage 1: operand and mode registers
	////////////////////////////////////////////////////////////

	calu_pkg::porta_t     a_q;
	calu_pkg::portb_t     b_q;
	calu_pkg::portc_t     c_q;
	calu_pkg::slice_alu_t alu_s1;
	logic                 use_z_s1;
	logic                 use_mult_s1;

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			a_q         <= '0;
			b_q         <= '0;
			c_q         <= '0;
			alu_s1      <= calu_pkg::ALU_Z_PLUS_M;
			use_z_s1    <= 1'b0;
			use_mult_s1 <= 1'b0;
		end else begin
			a_q         <= a_i;
			b_q         <= b_i;
			c_q         <= c_i;
			alu_s1      <= alu_i;
			use_z_s1    <= use_z_i;
			use_mult_s1 <= use_mult_i;
		end
	end

	////////////////////////////////////////////////////////////
	// stage 2: product M and addend Z
	////////////////////////////////////////////////////////////

	calu_pkg::portp_t     mult;   // full signed 30x18 product
	calu_pkg::portp_t     m_q;
	calu_pkg::portc_t     z_q;
	calu_pkg::slice_alu_t alu_s2; // follows the data down the pipe

	// both operands signed, so the product sign-extends to 48 bits
	assign mult = $signed(a_q) * $signed(b_q);

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			m_q    <= '0;
			z_q    <= '0;
			alu_s2 <= calu_pkg::ALU_Z_PLUS_M;
		end else begin
			m_q    <= use_mult_s1 ? mult : '0;
			z_q    <= use_z_s1 ? c_q : '0;
			alu_s2 <= alu_s1;
		end
	end

	////////////////////////////////////////////////////////////
	// stage 3: post-adder
	////////////////////////////////////////////////////////////

	calu_pkg::portp_t p_q;

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			p_q <= '0;
		end else begin
			if (alu_s2 == calu_pkg::ALU_Z_MINUS_M) begin
				p_q <= z_q - m_q;
			end else begin
				p_q <= z_q + m_q;
			end
		end
	end

	assign p_o = p_q;

endmodule

/* tests/complex_alu_props.sv */
`timescale 1ns/1ps

module complex_alu_props (
	input logic            clk,
	input logic            rst_n_i,
	input logic            valid_i,
	input logic            valid_o,
	input calu_pkg::cplx_t dout_o
);

	int unsigned assert_errors = 0; // read by the testbench
	logic        seen_valid;

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			seen_valid <= 1'b0;
		end else if (valid_o) begin
			seen_valid <= 1'b1;
		end
	end

	////////////////////////////////////////////////////////////
	// reset and valid timing
	////////////////////////////////////////////////////////////

	reset_quiet: assert property (@(posedge clk) !rst_n_i |=> !valid_o)
		else begin
			assert_errors++;
			$error("valid_o high during reset");
		end

	release_quiet: assert property (@(posedge clk) $rose(rst_n_i) |=> !valid_o)
		else begin
			assert_errors++;
			$error("valid_o high in the cycle after reset");
		end

	valid_delay: assert property (@(posedge clk) disable iff (!rst_n_i)
			valid_o == $past(valid_i, calu_pkg::CALU_LATENCY))
		else begin
			assert_errors++;
			$error("valid_o does not follow valid_i by the pipeline latency");
		end

	// nothing leaks out before the first result
	idle_zero: assert property (@(posedge clk) disable iff (!rst_n_i)
			(!seen_valid && !valid_o) |-> dout_o == '0)
		else begin
			assert_errors++;
			$error("dout_o not zero before the first result");
		end

endmodule

bind complex_alu_top complex_alu_props u_props (
	.clk     (clk),
	.rst_n_i (rst_n_i),
	.valid_i (valid_i),
	.valid_o (valid_o),
	.dout_o  (dout_o)
);

/* tests/complex_alu_tb.sv */
`timescale 1ns/1ps

module complex_alu_tb;

	localparam int    N_TRANS    = 24; // lines in the trace
	localparam int    BURST_LEN  = 15; // leading transactions sent back to back
	localparam int    MAX_GAP    = 3;
	localparam string TRACE_FILE = "tests/complex_alu_trace.txt";

	logic               clk;
	logic               rst_n_i;
	calu_pkg::calu_op_t op_i;
	logic               valid_i;
	calu_pkg::cplx_t    din_1_i;
	calu_pkg::cplx_t    din_2_i;
	calu_pkg::cplx_t    din_3_i;
	calu_pkg::cplx_t    dout_o;
	logic               valid_o;

	complex_alu_top u_dut (
		.clk     (clk),
		.rst_n_i (rst_n_i),
		.op_i    (op_i),
		.valid_i (valid_i),
		.din_1_i (din_1_i),
		.din_2_i (din_2_i),
		.din_3_i (din_3_i),
		.dout_o  (dout_o),
		.valid_o (valid_o)
	);

	////////////////////////////////////////////////////////////
	// clock, cycle counter, scoreboard state
	////////////////////////////////////////////////////////////

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	int          cycle_cnt   = 0;
	int          cycle_limit = 0;
	int          error_count = 0;
	int          result_idx  = 0;
	logic        seen_result = 1'b0;
	logic [31:0] trace_mem [0:5*N_TRANS-1]; // op, x, y, z, expected
	int          gap [0:N_TRANS-1];
	logic [31:0] exp_q [$];
	int          issue_q [$]; // cycle in which valid_i went high

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
	end

	task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
			input string what);
		if (actual !== expected) begin
			error_count++;
			$display("FAILED at %0t ns: %s, got %h, expected %h", $time, what, actual,
				expected);
		end
	endtask

	////////////////////////////////////////////////////////////
	// result monitor, samples on the falling edge
	////////////////////////////////////////////////////////////

	logic [31:0] exp_val;
	int          issue_cyc;

	always @(negedge clk) begin
		if (!rst_n_i) begin
			check_value(valid_o, 1'b0, "valid_o during reset");
		end else begin
			if (valid_i) begin
				issue_q.push_back(cycle_cnt);
			end
			if (valid_o) begin
				seen_result = 1'b1;
				if (exp_q.size() == 0) begin
					error_count++;
					$display("Unexpected result at %0t ns: valid_o high with nothing outstanding",
						$time);
				end else begin
					exp_val   = exp_q.pop_front();
					issue_cyc = issue_q.pop_front();
					result_idx++;
					check_value(dout_o, exp_val, $sformatf("result %0d dout_o", result_idx));
					check_value(cycle_cnt - issue_cyc, calu_pkg::CALU_LATENCY,
						$sformatf("result %0d valid_o latency", result_idx));
				end
			end else if (!seen_result) begin
				check_value(dout_o, '0, "dout_o before first result"); // idle pipe reads zero
			end
		end
	end

	////////////////////////////////////////////////////////////
	// stimulus
	////////////////////////////////////////////////////////////

	task automatic send_transaction(input int idx);
		@(posedge clk);
		op_i    <= calu_pkg::calu_op_t'(trace_mem[5*idx][1:0]);
		din_1_i <= trace_mem[5*idx+1];
		din_2_i <= trace_mem[5*idx+2];
		din_3_i <= trace_mem[5*idx+3];
		valid_i <= 1'b1;
		exp_q.push_back(trace_mem[5*idx+4]);
	endtask

	int unsigned seed_val;
	int          total_gap;
	int          drain_cnt;
	int          assert_cnt;

	initial begin
		rst_n_i = 1'b0;
		op_i    = calu_pkg::OP_CMUL_ADD;
		valid_i = 1'b0;
		din_1_i = 32'h7FFF_8001; // busy data under reset, must not reach dout_o
		din_2_i = 32'h8000_7FFF;
		din_3_i = 32'h1234_5678;

		$readmemh(TRACE_FILE, trace_mem);
		if ($isunknown(trace_mem[5*N_TRANS-1])) begin
			error_count++;
			$display("Trace file %s is missing or holds fewer than %0d lines", TRACE_FILE,
				N_TRANS);
		end

		seed_val  = $urandom(78);
		total_gap = 0;
		for (int i = 0; i < N_TRANS; i++) begin
			gap[i]    = (i < BURST_LEN) ? 0 : int'($urandom % (MAX_GAP + 1));
			total_gap = total_gap + gap[i];
		end
		cycle_limit = N_TRANS + total_gap + calu_pkg::CALU_LATENCY + 20;

		repeat (4) @(posedge clk);
		rst_n_i <= 1'b1;
		din_1_i <= '0; // quiet inputs until the first transaction
		din_2_i <= '0;
		din_3_i <= '0;

		for (int i = 0; i < N_TRANS; i++) begin
			repeat (gap[i]) begin
				@(posedge clk);
				valid_i <= 1'b0; // idle, data left as is
			end
			send_transaction(i);
		end
		@(posedge clk);
		valid_i <= 1'b0;

		// let the pipe drain
		drain_cnt = 0;
		while (exp_q.size() != 0 && drain_cnt < calu_pkg::CALU_LATENCY + 4) begin
			@(posedge clk);
			drain_cnt++;
		end
		repeat (2) @(posedge clk);
		if (exp_q.size() != 0) begin
			error_count++;
			$display("%0d results never came out of the DUT", exp_q.size());
		end

		assert_cnt = u_dut.u_props.assert_errors;
		$display("Summary: %0d results checked, %0d check errors, %0d assertion errors",
			result_idx, error_count, assert_cnt);
		if (error_count == 0 && assert_cnt == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

	// watchdog
	initial begin
		wait (cycle_limit != 0);
		while (cycle_cnt < cycle_limit) begin
			@(posedge clk);
		end
		$display("Timeout: the run did not finish within %0d cycles", cycle_limit);
		$display("Test failed");
		$finish;
	end

endmodule

/* tests/complex_alu_trace.txt */
// columns: op din_1 din_2 din_3 expected_dout, all hex, {re, im} Q1.15
// op: 0 cmul, 1 cmul by conjugate, 2 cmul plus z, 3 load z
0 40004000 40004000 00000000 00004000
0 4000C000 40004000 00000000 40000000
0 80000000 80000000 00000000 80000000
0 C0002000 4000C000 00000000 F0003000
0 FFFF0000 00010000 00000000 FFFF0000
0 7FFF7FFF 7FFF0000 00000000 7FFE7FFE
1 40004000 40004000 00000000 40000000
1 6000E000 6000E000 00000000 50000000
1 40002000 20004000 00000000 2000E800
2 40004000 40004000 2000E000 20002000
2 C0002000 4000C000 00000000 F0003000
2 80000000 40000000 40004000 00004000
2 FFFF0000 00010000 00010001 00000001
3 12345678 9ABCDEF0 7FFF8000 7FFF8000
3 80008000 80008000 0123FEDC 0123FEDC
0 20000000 00004000 00000000 00001000
1 00004000 00004000 00000000 20000000
2 40000000 40000000 C0000000 E0000000
3 FFFFFFFF 7FFF7FFF 5555AAAA 5555AAAA
0 40004000 C0004000 00000000 C0000000
1 C0004000 40004000 00000000 00004000
2 80008000 80000000 00000000 80008000
0 60000000 60000000 00000000 48000000
3 00000000 00000000 DEADBEEF DEADBEEF

/* verilog.f */
hdl/calu_pkg.sv
hdl/dsp_slice.sv
hdl/complex_op_decoder.sv
hdl/complex_alu.sv
hdl/complex_alu_top.sv
tests/complex_alu_props.sv
tests/complex_alu_tb.sv
